// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= fcc_tb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
EXTRA_ARGS ?=
FAIL_MSG   ?= Done: errors found
PASS_MSG   ?= Done: no errors

VFLAGS = --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA_ARGS) -f $(FILELIST)

# an assertion stop leaves no summary line, so a missing pass line also fails
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, no summary in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
+incdir+source
source/fcc_pkg.sv
source/fp32_classifier.sv
source/fp32_compare.sv
source/fcc_unit.sv
source/fcc_exec_top.sv
testbench/fcc_checker.sv
testbench/fcc_tb.sv

// ==== source/fcc_exec_top.sv ====
`timescale 1ns/1ns

module fcc_exec_top
    import fcc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      commit_fcc_i,
    input  logic      req_valid_i,
    output logic      req_ready_o,
    input  fcc_req_t  req_i,
    output logic      resp_valid_o,
    input  logic      resp_ready_i,
    output fcc_resp_t resp_o
);

    // integration boundary of the fcc subsystem
    fcc_unit i_fcc_unit (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .commit_fcc_i (commit_fcc_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_i        (req_i),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_o       (resp_o)
    );

endmodule

// ==== source/fcc_pkg.sv ====
`include "fcc_settings.svh"

package fcc_pkg;

    // instructions handled by the fcc unit
    typedef enum logic [2:0] {
        OP_MOV_TO_FCC   = 3'd0,
        OP_MOV_FROM_FCC = 3'd1,
        OP_FCMP         = 3'd2,
        OP_BCEQZ        = 3'd3,
        OP_BCNEZ        = 3'd4,
        OP_FSEL         = 3'd5,
        OP_FCLASS       = 3'd6
    } fcc_op_e;

    // cond[0] is the signalling compare, cond[4:1] enable ne, un, eq, lt
    typedef struct packed {
        fcc_op_e                op;
        logic [4:0]             cond;
        logic [`FCC_XLEN-1:0]   r0;
        logic [`FCC_XLEN-1:0]   r1;
        logic [`FCC_XLEN-1:0]   pc;
        logic [`FCC_IMM_W-1:0]  addr_imm;
    } fcc_req_t;

    typedef struct packed {
        logic [`FCC_XLEN-1:0]   result;
        logic                   need_jump;
        logic [`FCC_XLEN-1:0]   target_addr;
        logic                   invalid;
    } fcc_resp_t;

    // exactly one of zero/subnormal/normal/inf/nan is set
    typedef struct packed {
        logic is_zero;
        logic is_subnormal;
        logic is_normal;
        logic is_inf;
        logic is_nan;
        logic is_signalling;
        logic is_quiet;
    } fp_info_t;

    typedef struct packed {
        logic lt;
        logic eq;
        logic un;
        logic ne;
    } cmp_flags_t;

endpackage

// ==== source/fcc_settings.svh ====
`ifndef FCC_SETTINGS_SVH
`define FCC_SETTINGS_SVH

// data, operand and pc width
`define FCC_XLEN 32

// branch byte offset width, sign-extended to FCC_XLEN
`define FCC_IMM_W 23

`endif

// ==== source/fcc_unit.sv ====
`timescale 1ns/1ns

`include "fcc_settings.svh"

module fcc_unit
    import fcc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      commit_fcc_i,
    input  logic      req_valid_i,
    output logic      req_ready_o,
    input  fcc_req_t  req_i,
    output logic      resp_valid_o,
    input  logic      resp_ready_i,
    output fcc_resp_t resp_o
);

    fcc_req_t             req_q;
    logic                 valid_q;
    logic                 fcc_q;
    logic                 fcc_next;
    logic                 accept;
    logic                 resp_fire;
    fp_info_t             info_a;
    fp_info_t             info_b;
    cmp_flags_t           cmp_flags;
    logic                 any_signalling;
    logic                 any_nan;
    logic [`FCC_XLEN-1:0] imm_ext;

    // single slot, refilled while the held response leaves
    assign req_ready_o  = !valid_q || resp_ready_i;
    assign accept       = req_valid_i && req_ready_o;
    assign resp_fire    = valid_q && resp_ready_i;
    assign resp_valid_o = valid_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (req_ready_o) begin
            valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_i;
        end
    end

    // flush reloads the committed flag, a dropped instruction never updates
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fcc_q <= 1'b0;
        end else if (flush_i) begin
            fcc_q <= commit_fcc_i;
        end else if (resp_fire) begin
            fcc_q <= fcc_next;
        end
    end

    fp32_classifier i_class_a (
        .operand_i (req_q.r0),
        .info_o    (info_a)
    );

    fp32_classifier i_class_b (
        .operand_i (req_q.r1),
        .info_o    (info_b)
    );

    fp32_compare i_compare (
        .a_i      (req_q.r0),
        .b_i      (req_q.r1),
        .info_a_i (info_a),
        .info_b_i (info_b),
        .flags_o  (cmp_flags)
    );

    assign any_signalling = info_a.is_signalling || info_b.is_signalling;
    assign any_nan        = info_a.is_nan || info_b.is_nan;
    assign imm_ext = {{(`FCC_XLEN-`FCC_IMM_W){req_q.addr_imm[`FCC_IMM_W-1]}}, req_q.addr_imm};

    always_comb begin
        fcc_next = fcc_q;
        if (req_q.op == OP_FCMP) begin
            fcc_next = |(req_q.cond[4:1] & {cmp_flags.ne, cmp_flags.un,
                                            cmp_flags.eq, cmp_flags.lt});
        end else if (req_q.op == OP_MOV_TO_FCC) begin
            fcc_next = req_q.r0[0];
        end
    end

    // responses see fcc before this instruction's own update
    always_comb begin
        resp_o = '0;
        case (req_q.op)
            OP_MOV_FROM_FCC: begin
                resp_o.result[0] = fcc_q;
            end
            OP_FCMP: begin
                resp_o.invalid = any_signalling || (any_nan && req_q.cond[0]);
            end
            OP_BCEQZ, OP_BCNEZ: begin
                resp_o.need_jump   = (req_q.op == OP_BCNEZ) ? fcc_q : !fcc_q;
                resp_o.target_addr = req_q.pc + imm_ext;
            end
            OP_FSEL: begin
                resp_o.result  = fcc_q ? req_q.r1 : req_q.r0;
                resp_o.invalid = any_signalling;
            end
            OP_FCLASS: begin
                resp_o.result[0] = info_a.is_signalling;
                resp_o.result[1] = info_a.is_quiet;
                // negative classes in bits 2..5, positive in 6..9
                if (req_q.r0[`FCC_XLEN-1]) begin
                    resp_o.result[5:2] = {info_a.is_zero, info_a.is_subnormal,
                                          info_a.is_normal, info_a.is_inf};
                end else begin
                    resp_o.result[9:6] = {info_a.is_zero, info_a.is_subnormal,
                                          info_a.is_normal, info_a.is_inf};
                end
                resp_o.invalid = info_a.is_signalling;
            end
            default: begin
                resp_o = '0;
            end
        endcase
    end

endmodule

// ==== source/fp32_classifier.sv ====
`timescale 1ns/1ns

`include "fcc_settings.svh"

module fp32_classifier
    import fcc_pkg::*;
(
    input  logic [`FCC_XLEN-1:0] operand_i,
    output fp_info_t             info_o
);

    logic [7:0]  exponent;
    logic [22:0] mantissa;
    logic        exp_zero;
    logic        exp_ones;
    logic        man_zero;

    // sign bit is not needed for the class itself
    assign exponent = operand_i[30:23];
    assign mantissa = operand_i[22:0];

    assign exp_zero = (exponent == 8'h00);
    assign exp_ones = (exponent == 8'hff);
    assign man_zero = (mantissa == 23'd0);

    always_comb begin
        info_o              = '0;
        info_o.is_zero      = exp_zero && man_zero;
        info_o.is_subnormal = exp_zero && !man_zero;
        info_o.is_normal    = !exp_zero && !exp_ones;
        info_o.is_inf       = exp_ones && man_zero;
        info_o.is_nan       = exp_ones && !man_zero;
        // quiet bit is the top mantissa bit
        info_o.is_signalling = exp_ones && !man_zero && !mantissa[22];
        info_o.is_quiet      = exp_ones && mantissa[22];
    end

endmodule

// ==== source/fp32_compare.sv ====
`timescale 1ns/1ns

`include "fcc_settings.svh"

module fp32_compare
    import fcc_pkg::*;
(
    input  logic [`FCC_XLEN-1:0] a_i,
    input  logic [`FCC_XLEN-1:0] b_i,
    input  fp_info_t             info_a_i,
    input  fp_info_t             info_b_i,
    output cmp_flags_t           flags_o
);

    logic        any_nan;
    logic        both_zero;
    logic        equal;
    logic        raw_lt;
    logic [30:0] mag_a;
    logic [30:0] mag_b;

    assign any_nan   = info_a_i.is_nan || info_b_i.is_nan;
    assign both_zero = info_a_i.is_zero && info_b_i.is_zero;
    assign equal     = (a_i == b_i) || both_zero;

    assign mag_a = a_i[30:0];
    assign mag_b = b_i[30:0];

    // sign-magnitude ordering, zeros excluded through equal below
    always_comb begin
        case ({a_i[31], b_i[31]})
            2'b00:   raw_lt = mag_a < mag_b;
            2'b11:   raw_lt = mag_a > mag_b;
            2'b10:   raw_lt = 1'b1;
            default: raw_lt = 1'b0;
        endcase
    end

    assign flags_o.un = any_nan;
    assign flags_o.eq = !any_nan && equal;
    assign flags_o.lt = !any_nan && !equal && raw_lt;
    assign flags_o.ne = !any_nan && !equal;

endmodule

// ==== testbench/fcc_checker.sv ====
`timescale 1ns/1ns

module fcc_checker
    import fcc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      req_ready_i,
    input  logic      resp_valid_i,
    input  logic      resp_ready_i,
    input  fcc_resp_t resp_i
);

    // held response may not move until it is taken
    hold_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        resp_valid_i && !resp_ready_i && !flush_i |=> resp_valid_i && $stable(resp_i))
        else $error("response changed while back-pressured");

    // flush empties the slot
    flush_clears: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> !resp_valid_i)
        else $error("response valid still high after a flush");

    ready_rule: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_ready_i == (!resp_valid_i || resp_ready_i))
        else $error("request ready does not follow the single-slot rule");

endmodule

bind fcc_unit fcc_checker i_fcc_checker (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .req_ready_i  (req_ready_o),
    .resp_valid_i (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_i       (resp_o)
);

// ==== testbench/fcc_tb.sv ====
`timescale 1ns/1ns

`include "fcc_settings.svh"

module fcc_tb
    import fcc_pkg::*;
();

    localparam int XLEN     = `FCC_XLEN;
    localparam int IMM_W    = `FCC_IMM_W;
    localparam int TIMEOUT  = 100;
    localparam int NSPECIAL = 12;

    logic      clk;
    logic      rst_n;
    logic      flush;
    logic      commit_fcc;
    logic      req_valid;
    logic      req_ready;
    fcc_req_t  req;
    logic      resp_valid;
    logic      resp_ready = 1'b1;
    fcc_resp_t resp;

    fcc_resp_t exp_q[$];
    logic      model_fcc = 1'b0;
    int        bp_mode;
    int        responses = 0;
    int        errors = 0;
    int        main_errors;
    bit        aborted;

    fcc_exec_top i_fcc_exec_top (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .flush_i      (flush),
        .commit_fcc_i (commit_fcc),
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .req_i        (req),
        .resp_valid_o (resp_valid),
        .resp_ready_i (resp_ready),
        .resp_o       (resp)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // 0 always ready, 1 random, 2 held low
    always @(negedge clk) begin
        case (bp_mode)
            0:       resp_ready = 1'b1;
            1:       resp_ready = ($urandom_range(0, 2) != 0);
            default: resp_ready = 1'b0;
        endcase
    end

    // one-hot class mask as the fclass encoding defines it
    function automatic logic [9:0] class_mask(logic [XLEN-1:0] v);
        int idx;
        if (v[30:23] == 8'hff && v[22:0] != '0) begin
            return v[22] ? 10'b10 : 10'b01;
        end
        if (v[30:23] == 8'hff) idx = 0;
        else if (v[30:23] != 8'h00) idx = 1;
        else if (v[22:0] != '0) idx = 2;
        else idx = 3;
        return 10'd1 << (idx + 2 + (v[31] ? 0 : 4));
    endfunction

    // {ne, un, eq, lt} through a signed ordering key, so -0 and +0 meet at 0
    function automatic logic [3:0] cmp_model(logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        logic [9:0] ma;
        logic [9:0] mb;
        longint     ka;
        longint     kb;
        ma = class_mask(a);
        mb = class_mask(b);
        if (ma[1:0] != 2'b00 || mb[1:0] != 2'b00) return 4'b0100;
        ka = longint'(a[30:0]);
        kb = longint'(b[30:0]);
        if (a[31]) ka = -ka;
        if (b[31]) kb = -kb;
        return {ka != kb, 1'b0, ka == kb, ka < kb};
    endfunction

    function automatic fcc_resp_t fcc_model(fcc_req_t r, logic fcc, output logic fcc_next);
        fcc_resp_t  e;
        logic [9:0] ca;
        logic [9:0] cb;
        logic       nan_any;
        e = '0;
        fcc_next = fcc;
        ca = class_mask(r.r0);
        cb = class_mask(r.r1);
        nan_any = (ca[1:0] != 2'b00) || (cb[1:0] != 2'b00);
        case (r.op)
            OP_MOV_TO_FCC:   fcc_next = r.r0[0];
            OP_MOV_FROM_FCC: e.result = XLEN'(fcc);
            OP_FCMP: begin
                fcc_next  = |(r.cond[4:1] & cmp_model(r.r0, r.r1));
                e.invalid = ca[0] | cb[0] | (r.cond[0] & nan_any);
            end
            OP_BCEQZ, OP_BCNEZ: begin
                e.need_jump   = ((r.op == OP_BCNEZ) == fcc);
                e.target_addr = r.pc + XLEN'($signed(r.addr_imm));
            end
            OP_FSEL: begin
                e.result  = fcc ? r.r1 : r.r0;
                e.invalid = ca[0] | cb[0];
            end
            OP_FCLASS: begin
                e.result  = XLEN'(ca);
                e.invalid = ca[0];
            end
            default: ;
        endcase
        return e;
    endfunction

    function automatic int check_field(string name, logic [XLEN-1:0] want,
                                       logic [XLEN-1:0] got);
        assert (got === want) else begin
            $display("** Error: %s expected %h got %h", name, want, got);
        end
        return (got === want) ? 0 : 1;
    endfunction

    // compare taken responses first, then record the accepted request
    always @(posedge clk) begin
        fcc_resp_t want;
        fcc_resp_t pred;
        logic      nxt;
        if (resp_valid && resp_ready && !flush) begin
            assert (exp_q.size() != 0) else begin
                $display("a response arrived with no instruction outstanding");
                errors++;
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                responses++;
                errors += check_field("resp_o.result", want.result, resp.result);
                errors += check_field("resp_o.need_jump", XLEN'(want.need_jump),
                                      XLEN'(resp.need_jump));
                errors += check_field("resp_o.target_addr", want.target_addr,
                                      resp.target_addr);
                errors += check_field("resp_o.invalid", XLEN'(want.invalid),
                                      XLEN'(resp.invalid));
            end
        end
        if (flush) begin
            // held instruction is gone, committed flag takes over
            exp_q.delete();
            model_fcc = commit_fcc;
        end else if (req_valid && req_ready) begin
            pred = fcc_model(req, model_fcc, nxt);
            exp_q.push_back(pred);
            model_fcc = nxt;
        end
    end

    function automatic logic [XLEN-1:0] special_value(int idx);
        case (idx)
            0:       return 32'h0000_0000;
            1:       return 32'h8000_0000;
            2:       return 32'h7f80_0000;
            3:       return 32'hff80_0000;
            4:       return 32'h7fc0_0000;
            5:       return 32'hffc0_0001;
            6:       return 32'h7f80_0001;
            7:       return 32'hff9f_ffff;
            8:       return 32'h0000_0001;
            9:       return 32'h807f_ffff;
            10:      return 32'h3f80_0000;
            default: return 32'hc2c8_0000;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] pick_operand();
        int idx;
        idx = int'($urandom_range(0, NSPECIAL + 3));
        if (idx < NSPECIAL) return special_value(idx);
        return $urandom();
    endfunction

    function automatic fcc_req_t make_req(fcc_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        fcc_req_t r;
        r.op       = op;
        r.cond     = 5'($urandom());
        r.r0       = a;
        r.r1       = b;
        r.pc       = $urandom();
        r.addr_imm = IMM_W'($urandom());
        return r;
    endfunction

    function automatic int total_errors();
        return errors + main_errors;
    endfunction

    // leaves valid high so the next send can follow back to back
    task automatic send(fcc_req_t r);
        int waited;
        if (aborted) return;
        @(negedge clk);
        req_valid = 1'b1;
        req = r;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!req_ready && waited < TIMEOUT);
        if (!req_ready) begin
            $display("timeout: request not accepted within %0d cycles", TIMEOUT);
            aborted = 1'b1;
        end
    endtask

    task automatic drain();
        int waited;
        if (aborted) return;
        @(negedge clk);
        req_valid = 1'b0;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d responses never arrived", exp_q.size());
            aborted = 1'b1;
        end
    endtask

    task automatic set_backpressure(int mode);
        @(posedge clk);
        bp_mode = mode;
    endtask

    task automatic report(string name, int r0, int e0);
        $display("test %s: %0d responses, %0d errors", name, responses - r0,
                 total_errors() - e0);
    endtask

    task automatic test_reset();
        int r0 = responses;
        int e0 = total_errors();
        @(negedge clk);
        main_errors += check_field("resp_valid_o", XLEN'(1'b0), XLEN'(resp_valid));
        main_errors += check_field("req_ready_o", XLEN'(1'b1), XLEN'(req_ready));
        send(make_req(OP_MOV_FROM_FCC, 0, 0));
        send(make_req(OP_MOV_TO_FCC, 32'h0000_0001, 0));
        send(make_req(OP_MOV_FROM_FCC, 0, 0));
        send(make_req(OP_MOV_TO_FCC, 32'hffff_fffe, 0));
        send(make_req(OP_MOV_FROM_FCC, 0, 0));
        drain();
        report("reset", r0, e0);
    endtask

    task automatic test_compare();
        int          r0 = responses;
        int          e0 = total_errors();
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < 200 && !aborted; i++) begin
            a = pick_operand();
            // equal operands now and then
            b = ($urandom_range(0, 3) == 0) ? a : pick_operand();
            send(make_req(OP_FCMP, a, b));
            send(make_req(OP_MOV_FROM_FCC, a, b));
        end
        drain();
        report("fcmp", r0, e0);
    endtask

    task automatic test_classify();
        int r0 = responses;
        int e0 = total_errors();
        for (int i = 0; i < NSPECIAL && !aborted; i++) begin
            send(make_req(OP_FCLASS, special_value(i), 0));
        end
        for (int i = 0; i < 50 && !aborted; i++) begin
            send(make_req(OP_FCLASS, $urandom(), pick_operand()));
        end
        drain();
        report("fclass", r0, e0);
    endtask

    task automatic test_select_branch();
        int       r0 = responses;
        int       e0 = total_errors();
        fcc_op_e  ops[3] = '{OP_FSEL, OP_BCEQZ, OP_BCNEZ};
        fcc_req_t r;
        for (int i = 0; i < 100 && !aborted; i++) begin
            send(make_req(OP_MOV_TO_FCC, $urandom(), 0));
            r = make_req(ops[$urandom_range(0, 2)], pick_operand(), pick_operand());
            // alternate the offset sign
            r.addr_imm[IMM_W-1] = i[0];
            send(r);
        end
        drain();
        report("fsel/branch", r0, e0);
    endtask

    task automatic test_backpressure();
        int r0 = responses;
        int e0 = total_errors();
        set_backpressure(1);
        for (int i = 0; i < 200 && !aborted; i++) begin
            send(make_req(fcc_op_e'(3'($urandom_range(0, 6))), pick_operand(),
                          pick_operand()));
        end
        drain();
        set_backpressure(0);
        report("backpressure", r0, e0);
    endtask

    task automatic test_flush();
        int r0 = responses;
        int e0 = total_errors();
        for (int i = 0; i < 20 && !aborted; i++) begin
            send(make_req(OP_MOV_TO_FCC, $urandom(), 0));
            drain();
            // keep the next response held so the flush catches it
            set_backpressure(2);
            send(make_req(i[0] ? OP_MOV_TO_FCC : OP_FCMP, $urandom(), pick_operand()));
            @(negedge clk);
            req_valid = 1'b0;
            flush = 1'b1;
            commit_fcc = 1'($urandom());
            @(negedge clk);
            flush = 1'b0;
            set_backpressure(0);
            send(make_req(OP_MOV_FROM_FCC, 0, 0));
            drain();
        end
        report("flush", r0, e0);
    endtask

    initial begin
        void'($urandom(32'he35d_bbd4));
        rst_n       = 1'b0;
        flush       = 1'b0;
        commit_fcc  = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        bp_mode     = 0;
        main_errors = 0;
        aborted     = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_compare();
        test_classify();
        test_select_branch();
        test_backpressure();
        test_flush();
        $display("%0d responses checked, %0d errors, %0d timeouts", responses,
                 total_errors(), aborted);
        if (total_errors() == 0 && !aborted) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
